/* common/moxie_macros.svh */
// Moxie execute stage widths and stack layout constants

`ifndef MOXIE_MACROS_SVH
`define MOXIE_MACROS_SVH

// Data and address width in bits
`define MOXIE_XLEN 32

// Register file index width
`define MOXIE_REG_IDX_W 4

// Decoded opcode width
`define MOXIE_OP_W 6

// Register index of the stack pointer ($sp)
// $fp sits at index 0 and is never a write-back target
`define MOXIE_SP_INDEX 1

// A JSR instruction is six bytes long
// The return address is the byte right after it
`define MOXIE_RET_OFFSET 6

// Size of one stack word in bytes
// A call frame holds two words, the return address and the saved $fp
`define MOXIE_WORD_BYTES 4

`endif

/* common/moxie_pkg.sv */
// Moxie execute stage package with opcodes, step codes and stage payloads

`include "moxie_macros.svh"

package moxie_pkg;

  // Decoded opcodes handled by the execute stage
  // Any code not listed here executes as NOP
  typedef enum logic [`MOXIE_OP_W-1:0] {
    OP_NOP  = 6'h00,
    OP_LDI  = 6'h01,
    OP_MOV  = 6'h02,
    OP_RET  = 6'h04,
    OP_ADD  = 6'h05,
    OP_PUSH = 6'h06,
    OP_POP  = 6'h07,
    OP_LDA  = 6'h08,
    OP_STA  = 6'h09,
    OP_JSR  = 6'h19,
    OP_JMPA = 6'h1a,
    OP_JMP  = 6'h25,
    OP_AND  = 6'h26,
    OP_SUB  = 6'h29,
    OP_OR   = 6'h2b,
    OP_XOR  = 6'h2e,
    OP_INC  = 6'h30,
    OP_DEC  = 6'h31
  } exec_op_e;

  // What the stage issues in the current cycle
  typedef enum logic [1:0] {
    STEP_IDLE   = 2'd0,
    STEP_NORMAL = 2'd1,
    STEP_JSR2   = 2'd2,
    STEP_RET2   = 2'd3
  } seq_step_e;

  // One decoded instruction with its operands
  typedef struct packed {
    exec_op_e                    op;
    logic [`MOXIE_XLEN-1:0]      operand;
    logic [`MOXIE_XLEN-1:0]      reg_a;
    logic [`MOXIE_XLEN-1:0]      reg_b;
    logic [`MOXIE_REG_IDX_W-1:0] wr_idx;
    logic [`MOXIE_XLEN-1:0]      pc;
    logic [`MOXIE_XLEN-1:0]      sp;
    logic [`MOXIE_XLEN-1:0]      fp;
  } exec_in_t;

  // Register write-back request
  typedef struct packed {
    logic                        en;
    logic [`MOXIE_REG_IDX_W-1:0] idx;
    logic [`MOXIE_XLEN-1:0]      data;
  } reg_wr_t;

  // Memory request, at most one of rd and wr is set
  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic [`MOXIE_XLEN-1:0] addr;
    logic [`MOXIE_XLEN-1:0] wdata;
  } mem_req_t;

  // Branch request towards fetch
  typedef struct packed {
    logic                   valid;
    logic [`MOXIE_XLEN-1:0] target;
  } branch_t;

endpackage

/* execute/exec_sequencer.sv */
// Execute sequencer FSM for two-step calls and returns, with stall and branch outputs

`timescale 1ns/1ps

`include "moxie_macros.svh"

module exec_sequencer (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 stall_i,
  input  moxie_pkg::exec_in_t  instr_i,
  output moxie_pkg::seq_step_e step_o,
  output logic                 stall_o,
  output moxie_pkg::branch_t   branch_o
);
  import moxie_pkg::*;

  typedef enum logic [1:0] {
    ST_READY = 2'd0,
    ST_JSR2  = 2'd1,
    ST_RET2  = 2'd2
  } seq_state_e;

  seq_state_e             state_q;
  seq_state_e             state_d;
  logic                   two_step;
  logic                   valid_d;
  logic                   valid_q;
  logic [`MOXIE_XLEN-1:0] target_q;

  // Step decode, an external stall always wins
  always_comb
  begin
    if (stall_i)
      step_o = STEP_IDLE;
    else if (state_q == ST_JSR2)
      step_o = STEP_JSR2;
    else if (state_q == ST_RET2)
      step_o = STEP_RET2;
    else
      step_o = STEP_NORMAL;
  end

  assign two_step = (step_o == STEP_NORMAL) &&
                    (instr_i.op == OP_JSR || instr_i.op == OP_RET);

  always_comb
  begin
    state_d = state_q;
    if (step_o == STEP_NORMAL && instr_i.op == OP_JSR)
      state_d = ST_JSR2;
    else if (step_o == STEP_NORMAL && instr_i.op == OP_RET)
      state_d = ST_RET2;
    else if (step_o == STEP_JSR2 || step_o == STEP_RET2)
      state_d = ST_READY;
  end

  // Second step of JSR carries the call target
  assign valid_d = (step_o == STEP_JSR2) ||
                   (step_o == STEP_NORMAL && (instr_i.op == OP_JMP || instr_i.op == OP_JMPA));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q <= ST_READY;
      stall_o <= 1'b0;
      valid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Keep upstream holding while a second step waits out a stall
      stall_o <= two_step || (stall_i && state_q != ST_READY);
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i)
  begin
    target_q <= (instr_i.op == OP_JMP) ? instr_i.reg_a : instr_i.operand;
  end

  assign branch_o.valid  = valid_q;
  assign branch_o.target = target_q;

  // Second steps retire in one cycle unless stalled
  a_second_step_done: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (state_q != ST_READY && !stall_i) |=> (state_q == ST_READY));

  // Upstream is only held for a single extra cycle per call or return
  a_stall_one_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (stall_o && !stall_i) |=> !stall_o);

endmodule

/* execute/exec_alu.sv */
// Execute ALU producing the registered register write-back request

`timescale 1ns/1ps

`include "moxie_macros.svh"

module exec_alu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  moxie_pkg::exec_in_t  instr_i,
  input  moxie_pkg::seq_step_e step_i,
  output moxie_pkg::reg_wr_t   reg_wr_o
);
  import moxie_pkg::*;

  localparam logic [`MOXIE_XLEN-1:0] WORD  = `MOXIE_WORD_BYTES;
  localparam logic [`MOXIE_XLEN-1:0] FRAME = 2 * `MOXIE_WORD_BYTES;
  localparam logic [`MOXIE_REG_IDX_W-1:0] SP_IDX = `MOXIE_SP_INDEX;

  reg_wr_t wr_d;
  logic    en_q;
  logic [`MOXIE_REG_IDX_W-1:0] idx_q;
  logic [`MOXIE_XLEN-1:0]      data_q;

  always_comb
  begin
    wr_d.en   = 1'b0;
    wr_d.idx  = instr_i.wr_idx;
    wr_d.data = instr_i.operand;
    // Second steps and idle cycles write nothing
    if (step_i == STEP_NORMAL)
    begin
      wr_d.en = 1'b1;
      case (instr_i.op)
        OP_ADD:  wr_d.data = instr_i.reg_a + instr_i.reg_b;
        OP_SUB:  wr_d.data = instr_i.reg_a - instr_i.reg_b;
        OP_AND:  wr_d.data = instr_i.reg_a & instr_i.reg_b;
        OP_OR:   wr_d.data = instr_i.reg_a | instr_i.reg_b;
        OP_XOR:  wr_d.data = instr_i.reg_a ^ instr_i.reg_b;
        OP_MOV:  wr_d.data = instr_i.reg_b;
        OP_INC:  wr_d.data = instr_i.reg_a + instr_i.operand;
        OP_DEC:  wr_d.data = instr_i.reg_a - instr_i.operand;
        OP_LDI:  wr_d.data = instr_i.operand;
        // Pointer register update of the stack ops
        OP_PUSH: wr_d.data = instr_i.reg_a - WORD;
        OP_POP:  wr_d.data = instr_i.reg_a + WORD;
        OP_JSR:
        begin
          wr_d.idx  = SP_IDX;
          wr_d.data = instr_i.sp - FRAME;
        end
        OP_RET:
        begin
          wr_d.idx  = SP_IDX;
          wr_d.data = instr_i.sp + FRAME;
        end
        default: wr_d.en = 1'b0;
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
      en_q <= 1'b0;
    else
      en_q <= wr_d.en;
  end

  always_ff @(posedge clk_i)
  begin
    idx_q  <= wr_d.idx;
    data_q <= wr_d.data;
  end

  assign reg_wr_o.en   = en_q;
  assign reg_wr_o.idx  = idx_q;
  assign reg_wr_o.data = data_q;

  // Decode never targets $fp with a write-back
  a_no_fp_write: assert property (
    @(posedge clk_i) disable iff (rst_i)
    reg_wr_o.en |-> (reg_wr_o.idx != '0));

endmodule

/* execute/exec_mem_gen.sv */
// Memory request generator for loads, stores and the call and return stack frames

`timescale 1ns/1ps

`include "moxie_macros.svh"

module exec_mem_gen (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  moxie_pkg::exec_in_t  instr_i,
  input  moxie_pkg::seq_step_e step_i,
  output moxie_pkg::mem_req_t  mem_req_o
);
  import moxie_pkg::*;

  localparam logic [`MOXIE_XLEN-1:0] WORD    = `MOXIE_WORD_BYTES;
  localparam logic [`MOXIE_XLEN-1:0] FRAME   = 2 * `MOXIE_WORD_BYTES;
  localparam logic [`MOXIE_XLEN-1:0] RET_OFS = `MOXIE_RET_OFFSET;

  mem_req_t               req_d;
  logic                   rd_q;
  logic                   wr_q;
  logic [`MOXIE_XLEN-1:0] addr_q;
  logic [`MOXIE_XLEN-1:0] wdata_q;

  always_comb
  begin
    req_d.rd    = 1'b0;
    req_d.wr    = 1'b0;
    req_d.addr  = instr_i.operand;
    req_d.wdata = instr_i.reg_a;
    case (step_i)
      STEP_NORMAL:
      begin
        case (instr_i.op)
          OP_LDA:
            req_d.rd = 1'b1;
          OP_STA:
            req_d.wr = 1'b1;
          OP_PUSH:
          begin
            req_d.wr    = 1'b1;
            req_d.addr  = instr_i.reg_a - WORD;
            req_d.wdata = instr_i.reg_b;
          end
          OP_POP:
          begin
            req_d.rd   = 1'b1;
            req_d.addr = instr_i.reg_a;
          end
          // Return address goes to the lower word of the new frame
          OP_JSR:
          begin
            req_d.wr    = 1'b1;
            req_d.addr  = instr_i.sp - FRAME;
            req_d.wdata = instr_i.pc + RET_OFS;
          end
          OP_RET:
          begin
            req_d.rd   = 1'b1;
            req_d.addr = instr_i.sp;
          end
          default: ;
        endcase
      end
      // Saved $fp sits in the upper word of the frame
      STEP_JSR2:
      begin
        req_d.wr    = 1'b1;
        req_d.addr  = instr_i.sp - WORD;
        req_d.wdata = instr_i.fp;
      end
      STEP_RET2:
      begin
        req_d.rd   = 1'b1;
        req_d.addr = instr_i.sp + WORD;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      rd_q <= 1'b0;
      wr_q <= 1'b0;
    end
    else
    begin
      rd_q <= req_d.rd;
      wr_q <= req_d.wr;
    end
  end

  always_ff @(posedge clk_i)
  begin
    addr_q  <= req_d.addr;
    wdata_q <= req_d.wdata;
  end

  assign mem_req_o.rd    = rd_q;
  assign mem_req_o.wr    = wr_q;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = wdata_q;

  a_rd_wr_excl: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(mem_req_o.rd && mem_req_o.wr));

endmodule

/* source/moxie_execute.sv */
// Moxie execute stage top level joining sequencer, ALU and memory generator

`timescale 1ns/1ps

`include "moxie_macros.svh"

module moxie_execute (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                stall_i,
  input  moxie_pkg::exec_in_t instr_i,
  output moxie_pkg::reg_wr_t  reg_wr_o,
  output moxie_pkg::mem_req_t mem_req_o,
  output moxie_pkg::branch_t  branch_o,
  output logic                stall_o
);
  import moxie_pkg::*;

  // Shared step code, decided in the same cycle
  seq_step_e step;

  exec_sequencer exec_sequencer_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .stall_i  (stall_i),
    .instr_i  (instr_i),
    .step_o   (step),
    .stall_o  (stall_o),
    .branch_o (branch_o)
  );

  exec_alu exec_alu_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .instr_i  (instr_i),
    .step_i   (step),
    .reg_wr_o (reg_wr_o)
  );

  exec_mem_gen exec_mem_gen_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .instr_i   (instr_i),
    .step_i    (step),
    .mem_req_o (mem_req_o)
  );

endmodule

/* tb/tb_checks.svh */
// Concurrent checks comparing the execute stage outputs with the reference model

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // Reset leaves every enable, valid bit and stall_o low
  a_reset_quiet: assert property (@(negedge clk_i)
    rst_i |-> !(reg_wr_o.en || mem_req_o.rd || mem_req_o.wr || branch_o.valid || stall_o))
  else
  begin
    value_errors = value_errors + 1;
    $display("mismatch at %0t: an enable or stall_o is set during reset", $time);
  end

  a_reg_match: assert property (@(negedge clk_i) disable iff (rst_i)
    (reg_wr_o.en == exp_reg.en) &&
    (!exp_reg.en || (reg_wr_o.idx == exp_reg.idx && reg_wr_o.data == exp_reg.data)))
  else
  begin
    value_errors = value_errors + 1;
    $display("mismatch at %0t: reg_wr_o en %0b idx %0d data %h, expected en %0b idx %0d data %h",
             $time, reg_wr_o.en, reg_wr_o.idx, reg_wr_o.data,
             exp_reg.en, exp_reg.idx, exp_reg.data);
  end

  a_mem_match: assert property (@(negedge clk_i) disable iff (rst_i)
    (mem_req_o.rd == exp_mem.rd) && (mem_req_o.wr == exp_mem.wr) &&
    (!(exp_mem.rd || exp_mem.wr) || mem_req_o.addr == exp_mem.addr) &&
    (!exp_mem.wr || mem_req_o.wdata == exp_mem.wdata))
  else
  begin
    value_errors = value_errors + 1;
    $display("mismatch at %0t: mem_req_o rd %0b wr %0b addr %h wdata %h, expected %0b %0b %h %h",
             $time, mem_req_o.rd, mem_req_o.wr, mem_req_o.addr, mem_req_o.wdata,
             exp_mem.rd, exp_mem.wr, exp_mem.addr, exp_mem.wdata);
  end

  a_branch_match: assert property (@(negedge clk_i) disable iff (rst_i)
    (branch_o.valid == exp_branch.valid) &&
    (!exp_branch.valid || branch_o.target == exp_branch.target))
  else
  begin
    value_errors = value_errors + 1;
    $display("mismatch at %0t: branch_o valid %0b target %h, expected valid %0b target %h",
             $time, branch_o.valid, branch_o.target, exp_branch.valid, exp_branch.target);
  end

  a_stall_match: assert property (@(negedge clk_i) disable iff (rst_i)
    stall_o == exp_stall)
  else
  begin
    value_errors = value_errors + 1;
    $display("mismatch at %0t: stall_o is %0b, expected %0b", $time, stall_o, exp_stall);
  end

  // Nothing is issued in a cycle that was stalled at the edge
  a_stall_quiet: assert property (@(negedge clk_i) disable iff (rst_i)
    stalled_q |-> !(reg_wr_o.en || mem_req_o.rd || mem_req_o.wr || branch_o.valid))
  else
  begin
    value_errors = value_errors + 1;
    $display("mismatch at %0t: an enable is set after a stalled edge", $time);
  end

`endif

/* tb/tb_moxie_execute.sv */
// Testbench for the Moxie execute stage with random stimulus and a reference model

`timescale 1ns/1ps

`include "moxie_macros.svh"

module tb_moxie_execute;
  import moxie_pkg::*;

  localparam logic [31:0] SEED = 32'hfc48_d891;
  localparam int N_RANDOM = 600;
  localparam int ACCEPT_LIMIT = 20;
  localparam logic [`MOXIE_XLEN-1:0] WORD = `MOXIE_WORD_BYTES;
  localparam logic [`MOXIE_XLEN-1:0] FRAME = 2 * `MOXIE_WORD_BYTES;
  localparam logic [`MOXIE_XLEN-1:0] RET_OFS = `MOXIE_RET_OFFSET;
  localparam logic [`MOXIE_REG_IDX_W-1:0] SP_IDX = `MOXIE_SP_INDEX;

  logic     clk_i;
  logic     rst_i;
  logic     stall_i;
  exec_in_t instr_i;
  reg_wr_t  reg_wr_o;
  mem_req_t mem_req_o;
  branch_t  branch_o;
  logic     stall_o;

  // Model phase 0 is ready, 1 waits for the JSR second step, 2 for the RET second step
  logic [1:0]  phase_q;
  seq_step_e   model_step;
  reg_wr_t     exp_reg;
  mem_req_t    exp_mem;
  branch_t     exp_branch;
  logic        exp_stall;
  logic        stalled_q;
  logic [31:0] rng_state;
  int          value_errors;
  int          timeout_errors;
  exec_in_t    ins;
  int          k;

  moxie_execute moxie_execute_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .stall_i   (stall_i),
    .instr_i   (instr_i),
    .reg_wr_o  (reg_wr_o),
    .mem_req_o (mem_req_o),
    .branch_o  (branch_o),
    .stall_o   (stall_o)
  );

  `include "tb_checks.svh"

  initial
  begin
    clk_i = 1'b0;
  end

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw(output logic [31:0] v);
    rng_state = xorshift32(rng_state);
    v = rng_state;
  endtask

  function automatic exec_op_e pick_op(input int sel);
    exec_op_e op;
    case (sel)
      0: op = OP_LDI;
      1: op = OP_MOV;
      2: op = OP_RET;
      3: op = OP_ADD;
      4: op = OP_PUSH;
      5: op = OP_POP;
      6: op = OP_LDA;
      7: op = OP_STA;
      8: op = OP_JSR;
      9: op = OP_JMPA;
      10: op = OP_JMP;
      11: op = OP_AND;
      12: op = OP_SUB;
      13: op = OP_OR;
      14: op = OP_XOR;
      15: op = OP_INC;
      16: op = OP_DEC;
      17: op = OP_NOP;
      // Unlisted code acts as NOP
      default: op = exec_op_e'(6'h3f);
    endcase
    return op;
  endfunction

  task automatic make_instr(input int sel, output exec_in_t ni);
    logic [31:0] r;
    draw(r);
    ni.operand = r;
    draw(r);
    ni.reg_a = r;
    draw(r);
    ni.reg_b = r;
    draw(r);
    ni.pc = r;
    draw(r);
    ni.sp = r;
    draw(r);
    ni.fp = r;
    draw(r);
    // Index 0 is $fp and never a write-back target
    ni.wr_idx = (r[3:0] == 4'd0) ? 4'd1 : r[3:0];
    ni.op = pick_op(sel);
  endtask

  function automatic reg_wr_t alu_writeback(input exec_in_t ni, input seq_step_e step);
    reg_wr_t w;
    w = '0;
    if (step == STEP_NORMAL)
    begin
      w.en = 1'b1;
      w.idx = ni.wr_idx;
      case (ni.op)
        OP_ADD: w.data = ni.reg_a + ni.reg_b;
        OP_SUB: w.data = ni.reg_a - ni.reg_b;
        OP_AND: w.data = ni.reg_a & ni.reg_b;
        OP_OR: w.data = ni.reg_a | ni.reg_b;
        OP_XOR: w.data = ni.reg_a ^ ni.reg_b;
        OP_MOV: w.data = ni.reg_b;
        OP_INC: w.data = ni.reg_a + ni.operand;
        OP_DEC: w.data = ni.reg_a - ni.operand;
        OP_LDI: w.data = ni.operand;
        OP_PUSH: w.data = ni.reg_a - WORD;
        OP_POP: w.data = ni.reg_a + WORD;
        OP_JSR:
        begin
          w.idx = SP_IDX;
          w.data = ni.sp - FRAME;
        end
        OP_RET:
        begin
          w.idx = SP_IDX;
          w.data = ni.sp + FRAME;
        end
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  function automatic mem_req_t mem_access(input exec_in_t ni, input seq_step_e step);
    mem_req_t m;
    m = '0;
    if (step == STEP_JSR2)
    begin
      m.wr = 1'b1;
      m.addr = ni.sp - WORD;
      m.wdata = ni.fp;
    end
    else if (step == STEP_RET2)
    begin
      m.rd = 1'b1;
      m.addr = ni.sp + WORD;
    end
    else if (step == STEP_NORMAL)
    begin
      case (ni.op)
        OP_LDA:
        begin
          m.rd = 1'b1;
          m.addr = ni.operand;
        end
        OP_STA:
        begin
          m.wr = 1'b1;
          m.addr = ni.operand;
          m.wdata = ni.reg_a;
        end
        OP_PUSH:
        begin
          m.wr = 1'b1;
          m.addr = ni.reg_a - WORD;
          m.wdata = ni.reg_b;
        end
        OP_POP:
        begin
          m.rd = 1'b1;
          m.addr = ni.reg_a;
        end
        OP_JSR:
        begin
          m.wr = 1'b1;
          m.addr = ni.sp - FRAME;
          m.wdata = ni.pc + RET_OFS;
        end
        OP_RET:
        begin
          m.rd = 1'b1;
          m.addr = ni.sp;
        end
        default: m = '0;
      endcase
    end
    return m;
  endfunction

  function automatic branch_t branch_request(input exec_in_t ni, input seq_step_e step);
    branch_t b;
    b = '0;
    if (step == STEP_JSR2 || (step == STEP_NORMAL && ni.op == OP_JMPA))
    begin
      b.valid = 1'b1;
      b.target = ni.operand;
    end
    else if (step == STEP_NORMAL && ni.op == OP_JMP)
    begin
      b.valid = 1'b1;
      b.target = ni.reg_a;
    end
    return b;
  endfunction

  always_comb
  begin
    if (stall_i)
      model_step = STEP_IDLE;
    else if (phase_q == 2'd1)
      model_step = STEP_JSR2;
    else if (phase_q == 2'd2)
      model_step = STEP_RET2;
    else
      model_step = STEP_NORMAL;
  end

  // Reference model holds what the DUT must show after this edge
  always @(posedge clk_i)
  begin
    if (rst_i)
    begin
      phase_q <= 2'd0;
      exp_reg <= '0;
      exp_mem <= '0;
      exp_branch <= '0;
      exp_stall <= 1'b0;
      stalled_q <= 1'b0;
    end
    else
    begin
      exp_reg <= alu_writeback(instr_i, model_step);
      exp_mem <= mem_access(instr_i, model_step);
      exp_branch <= branch_request(instr_i, model_step);
      stalled_q <= stall_i;
      exp_stall <= (model_step == STEP_NORMAL && (instr_i.op == OP_JSR || instr_i.op == OP_RET))
                   || (stall_i && phase_q != 2'd0);
      if (model_step == STEP_NORMAL && instr_i.op == OP_JSR)
        phase_q <= 2'd1;
      else if (model_step == STEP_NORMAL && instr_i.op == OP_RET)
        phase_q <= 2'd2;
      else if (model_step == STEP_JSR2 || model_step == STEP_RET2)
        phase_q <= 2'd0;
    end
  end

  // Present one instruction until the stage takes it
  // Stall mode 0 never stalls, 1 stalls at random, 2 stalls the two edges after the first step
  task automatic issue(input exec_in_t ni, input int stall_mode);
    int          cycles;
    logic        done;
    logic [31:0] r;
    cycles = 0;
    done = 1'b0;
    instr_i = ni;
    while (!done)
    begin
      draw(r);
      if (stall_mode == 1)
        stall_i = (r[1:0] == 2'b00);
      else if (stall_mode == 2)
        stall_i = (cycles == 1 || cycles == 2);
      else
        stall_i = 1'b0;
      @(negedge clk_i);
      cycles++;
      if (!stall_i && !stall_o)
        done = 1'b1;
      else if (cycles > ACCEPT_LIMIT)
      begin
        timeout_errors = timeout_errors + 1;
        $display("Instruction with opcode %0h was not accepted within %0d cycles",
                 ni.op, ACCEPT_LIMIT);
        done = 1'b1;
      end
    end
  endtask

  initial
  begin
    rng_state = SEED;
    value_errors = 0;
    timeout_errors = 0;
    rst_i = 1'b1;
    stall_i = 1'b0;
    instr_i = '0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    // Every opcode once without stalls
    for (k = 0; k < 19; k++)
    begin
      make_instr(k, ins);
      issue(ins, 0);
    end
    // Call and return interrupted before their second step
    make_instr(8, ins);
    issue(ins, 2);
    make_instr(2, ins);
    issue(ins, 2);
    for (k = 0; k < N_RANDOM; k++)
    begin
      draw(rng_state);
      make_instr(int'(rng_state % 19), ins);
      issue(ins, 1);
    end
    stall_i = 1'b0;
    instr_i = '0;
    @(negedge clk_i);
    @(negedge clk_i);
    $display("Error count: %0d mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

/* compile.f */
+incdir+common
+incdir+tb
common/moxie_pkg.sv
execute/exec_sequencer.sv
execute/exec_alu.sv
execute/exec_mem_gen.sv
source/moxie_execute.sv
tb/tb_moxie_execute.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_moxie_execute -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_moxie_execute)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
  exit 0
fi
exit 1
